/* mem_golden.txt */
# L line beat data | F addr instr | W addr byte_en data | R addr word
# B addr strobed_addr instr, second strobe while the first fetch is busy
L 00 0 1000000110000000
L 00 1 1000000310000002
L 00 2 1000000510000004
L 00 3 1000000710000006
L 02 0 2000000120000000
L 02 1 2000000320000002
L 02 2 2000000520000004
L 02 3 2000000720000006
L 01 0 3000000130000000
L 01 1 3000000330000002
L 01 2 3000000530000004
L 01 3 3000000730000006
# refill, hits, conflict on line index 0, refill of the evicted line
F 005 10000005
F 002 10000002
F 007 10000007
F 00B 30000003
F 013 20000003
F 016 20000006
F 001 10000001
B 004 00C 10000004
B 014 00E 20000004
F 00E 30000006
F 011 20000001
# data port byte lanes
W 010 F 11223344
W 010 5 AABBCCDD
R 010 11BB33DD
W 3FF F DEADBEEF
W 3FF 8 5A000000
R 3FF 5AADBEEF
W 3FF 2 0000C300
R 3FF 5AADC3EF
R 010 11BB33DD

/* verilog.f */
mem_pkg.sv
data_ram.sv
icache_tags.sv
icache_lines.sv
icache_ctrl.sv
burst_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_mem_subsys
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --timescale 1ns/1ps
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_mem_subsys.sv */
// ~~~~~~~~~~~~~~~~~~~~
// memory subsystem testbench
// replays the golden file on the load, fetch and data ports
// ~~~~~~~~~~~~~~~~~~~~
module tb_mem_subsys import mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 200;
  // idle window after each ready pulse
  localparam int QUIET_CYCLES   = 12;

  logic                  clk;
  logic                  rst;
  logic                  fetch_en;
  fetch_addr_u           fetch_addr;
  logic                  fetch_busy;
  logic                  fetch_ready;
  logic [INSTR_BITS-1:0] fetch_instr;
  logic [3:0]            data_we;
  logic [9:0]            data_addr;
  logic [INSTR_BITS-1:0] data_wdata;
  logic [INSTR_BITS-1:0] data_rdata;
  load_t                 load;

  // reference models of burst ram image, cache tags and data ram
  logic [BEAT_BITS-1:0]  image [2**(LINE_ADDR_BITS + BEAT_IX_BITS)];
  logic [TAG_BITS-1:0]   model_tag [2**LINE_IX_BITS];
  logic                  model_valid [2**LINE_IX_BITS];
  logic [INSTR_BITS-1:0] shadow [1024];

  int errors;
  int timeouts;

  mem_subsys_top #(.DATA_DEPTH_BITS(10), .BURST_LATENCY(3)) mem_subsys_top_inst (
    .clk(clk), .rst(rst),
    .fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_busy(fetch_busy),
    .fetch_ready(fetch_ready), .fetch_instr(fetch_instr),
    .data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata),
    .data_rdata(data_rdata), .load(load)
  );

  always #50 clk = ~clk;

  // word w of a line is half (w mod 2) of beat w/2, low half first
  function automatic logic [INSTR_BITS-1:0] image_word(input logic [9:0] a);
    logic [BEAT_BITS-1:0] beat;
    beat = image[{a[9:3], a[2:1]}];
    return a[0] ? beat[63:32] : beat[31:0];
  endfunction

  task automatic load_beat(input logic [6:0] line, input logic [1:0] beat,
                           input logic [63:0] data);
    load.en        = 1'b1;
    load.line_addr = line;
    load.beat      = beat;
    load.data      = data;
    image[{line, beat}] = data;
    @(posedge clk);
    @(negedge clk);
    load.en = 1'b0;
  endtask

  task automatic write_data(input logic [9:0] addr, input logic [3:0] be,
                            input logic [31:0] wd);
    data_addr  = addr;
    data_we    = be;
    data_wdata = wd;
    // only enabled lanes change in the shadow word
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        shadow[addr][i*8 +: 8] = wd[i*8 +: 8];
      end
    end
    @(posedge clk);
    @(negedge clk);
    data_we = '0;
  endtask

  task automatic read_data(input logic [9:0] addr, input logic [31:0] gold);
    data_addr = addr;
    data_we   = '0;
    @(posedge clk);
    @(negedge clk);
    if (gold !== shadow[addr]) begin
      $display("[ERROR] %0t: golden word %h at %h, shadow holds %h",
               $time, gold, addr, shadow[addr]);
      errors++;
    end
    if (data_rdata !== shadow[addr]) begin
      $display("[ERROR] %0t: data read at %h gave %h, expected %h",
               $time, addr, data_rdata, shadow[addr]);
      errors++;
    end
  endtask

  // one fetch, optionally with a second strobe while the first is busy
  task automatic run_fetch(input logic [9:0] addr, input logic [31:0] gold,
                           input bit strobe_busy, input logic [9:0] addr2);
    fetch_addr_u fa;
    logic        hit_pred;
    logic [31:0] want;
    int          n;
    int          edges;
    bit          got;
    int          extra;
    fa.flat  = addr;
    hit_pred = model_valid[fa.f.line] && (model_tag[fa.f.line] == fa.f.tag);
    want     = image_word(addr);
    if (gold !== want) begin
      $display("[ERROR] %0t: golden instr %h for %h, image gives %h", $time, gold, addr, want);
      errors++;
    end
    n = 0;
    while (fetch_busy && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (fetch_busy) begin
      $display("timeout: fetch port never went idle before fetch of %h", addr);
      timeouts++;
      return;
    end
    fetch_en        = 1'b1;
    fetch_addr.flat = addr;
    @(posedge clk);
    @(negedge clk);
    // lands on the lookup edge, must be dropped
    fetch_en        = strobe_busy;
    fetch_addr.flat = addr2;
    edges = 0;
    got   = 1'b0;
    while (!got && edges < TIMEOUT_CYCLES) begin
      if (!fetch_busy) begin
        $display("[ERROR] %0t: fetch_busy low before fetch_ready for %h", $time, addr);
        errors++;
      end
      @(posedge clk);
      @(negedge clk);
      edges++;
      fetch_en = 1'b0;
      got      = fetch_ready;
    end
    if (!got) begin
      $display("timeout: no fetch_ready within %0d cycles for address %h", TIMEOUT_CYCLES, addr);
      timeouts++;
      return;
    end
    if (fetch_instr !== want) begin
      $display("[ERROR] %0t: fetch %h gave %h, expected %h", $time, addr, fetch_instr, want);
      errors++;
    end
    // hit answers two edges after acceptance, a refill takes longer
    if ((hit_pred && edges != 2) || (!hit_pred && edges <= 2)) begin
      $display("[ERROR] %0t: fetch %h ready after %0d edges, hit expected %0b",
               $time, addr, edges, hit_pred);
      errors++;
    end
    model_tag[fa.f.line]   = fa.f.tag;
    model_valid[fa.f.line] = 1'b1;
    // single ready pulse, and a dropped strobe starts nothing
    extra = 0;
    for (n = 0; n < QUIET_CYCLES; n++) begin
      @(negedge clk);
      if (fetch_ready || fetch_busy) extra++;
    end
    if (extra != 0) begin
      $display("[ERROR] %0t: fetch port active %0d cycles after ready for %h",
               $time, extra, addr);
      errors++;
    end
  endtask

  initial begin
    int               fd;
    int               code;
    logic [7:0]       op;
    logic [63:0]      f1;
    logic [63:0]      f2;
    logic [63:0]      f3;
    logic [8*160-1:0] skip;
    clk        = 1'b0;
    rst        = 1'b1;
    fetch_en   = 1'b0;
    fetch_addr = '0;
    data_we    = '0;
    data_addr  = '0;
    data_wdata = '0;
    load       = '0;
    errors     = 0;
    timeouts   = 0;
    for (int i = 0; i < 2**LINE_IX_BITS; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (fetch_busy || fetch_ready) begin
      $display("[ERROR] %0t: fetch port not idle after reset", $time);
      errors++;
    end
    fd = $fopen("mem_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open mem_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", op);
        if (code == 1) begin
          if (op == "#") begin
            code = $fgets(skip, fd);
          end else begin
            if (op == "F" || op == "R") begin
              code = $fscanf(fd, "%h %h", f1, f2) + 1;
            end else begin
              code = $fscanf(fd, "%h %h %h", f1, f2, f3);
            end
            if (code != 3) begin
              $display("golden file line for op %c has missing fields", op);
              errors++;
            end else begin
              case (op)
                "L": load_beat(f1[6:0], f2[1:0], f3);
                "F": run_fetch(f1[9:0], f2[31:0], 1'b0, f1[9:0]);
                "B": run_fetch(f1[9:0], f3[31:0], 1'b1, f2[9:0]);
                "W": write_data(f1[9:0], f2[3:0], f3[31:0]);
                "R": read_data(f1[9:0], f2[31:0]);
                default: begin
                  $display("unknown op %c in golden file", op);
                  errors++;
                end
              endcase
            end
          end
        end
      end
      $fclose(fd);
    end
    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* mem_subsys_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// memory subsystem top
// data ram on port A, cached instruction fetch on port B
// ~~~~~~~~~~~~~~~~~~~~
module mem_subsys_top import mem_pkg::*; #(
  parameter int DATA_DEPTH_BITS = 10,
  parameter int BURST_LATENCY   = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  // port B, instruction fetch
  input  logic                       fetch_en,
  input  fetch_addr_u                fetch_addr,
  output logic                       fetch_busy,
  output logic                       fetch_ready,
  output logic [INSTR_BITS-1:0]      fetch_instr,
  // port A, data
  input  logic [INSTR_BITS/8-1:0]    data_we,
  input  logic [DATA_DEPTH_BITS-1:0] data_addr,
  input  logic [INSTR_BITS-1:0]      data_wdata,
  output logic [INSTR_BITS-1:0]      data_rdata,
  // program image preload
  input  load_t                      load
);

  fetch_addr_u             cur_addr;
  logic                    tag_hit;
  logic                    tag_set;
  logic                    beat_we;
  logic [BEAT_IX_BITS-1:0] beat_ix;
  br_req_t                 br_req;
  br_rsp_t                 br_rsp;

  icache_ctrl icache_ctrl_inst (
    .clk(clk), .rst(rst),
    .fetch_en(fetch_en), .fetch_addr(fetch_addr),
    .fetch_busy(fetch_busy), .fetch_ready(fetch_ready),
    .cur_addr(cur_addr), .tag_hit(tag_hit), .tag_set(tag_set),
    .beat_we(beat_we), .beat_ix(beat_ix),
    .br_req(br_req), .br_rsp(br_rsp)
  );

  icache_tags icache_tags_inst (
    .clk(clk), .rst(rst), .lookup(cur_addr), .set(tag_set), .hit(tag_hit)
  );

  // beat data comes straight off the burst link
  icache_lines icache_lines_inst (
    .clk(clk), .addr(cur_addr), .beat_we(beat_we), .beat_ix(beat_ix),
    .beat_data(br_rsp.rd_data), .instr(fetch_instr)
  );

  burst_ram #(.LATENCY(BURST_LATENCY)) burst_ram_inst (
    .clk(clk), .rst(rst), .req(br_req), .rsp(br_rsp), .load(load)
  );

  data_ram #(.DEPTH_BITS(DATA_DEPTH_BITS)) data_ram_inst (
    .clk(clk), .we(data_we), .addr(data_addr), .wdata(data_wdata), .rdata(data_rdata)
  );

endmodule

/* burst_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// backing burst ram
// answers a line request with four beats after a fixed latency
// ~~~~~~~~~~~~~~~~~~~~
module burst_ram import mem_pkg::*; #(
  parameter int LATENCY = 3
) (
  input  logic    clk,
  input  logic    rst,
  input  br_req_t req,
  output br_rsp_t rsp,
  input  load_t   load
);

  localparam int LAT_BITS = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  typedef enum logic [1:0] {B_IDLE, B_WAIT, B_STREAM} bstate_t;

  // 128 lines of four beats, index {line, beat}
  logic [BEAT_BITS-1:0] mem [2**(LINE_ADDR_BITS + BEAT_IX_BITS)];

  bstate_t                   state;
  logic [LINE_ADDR_BITS-1:0] line_q;
  logic [LAT_BITS-1:0]       lat_cnt;
  logic [BEAT_IX_BITS-1:0]   beat_cnt;
  logic                      busy_q;
  logic                      valid_q;
  logic [BEAT_BITS-1:0]      data_q;

  assign rsp.busy     = busy_q;
  assign rsp.rd_valid = valid_q;
  assign rsp.rd_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= B_IDLE;
      busy_q   <= 1'b0;
      valid_q  <= 1'b0;
      lat_cnt  <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        // busy drops one cycle after the last beat
        B_IDLE: begin
          valid_q <= 1'b0;
          busy_q  <= req.cmd_en;
          lat_cnt <= '0;
          if (req.cmd_en) state <= B_WAIT;
        end
        B_WAIT: begin
          if (lat_cnt == LAT_BITS'(LATENCY - 1)) begin
            beat_cnt <= '0;
            state    <= B_STREAM;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        // lowest beat first, back to back
        B_STREAM: begin
          valid_q  <= 1'b1;
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == BEAT_IX_BITS'(BEATS_PER_LINE - 1)) state <= B_IDLE;
        end
        default: state <= B_IDLE;
      endcase
    end
  end

  // line address held for the whole burst
  always_ff @(posedge clk) begin
    if ((state == B_IDLE) && req.cmd_en) begin
      line_q <= req.line_addr;
    end
  end

  // preload port and beat readout
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[{load.line_addr, load.beat}] <= load.data;
    end
    if (state == B_STREAM) begin
      data_q <= mem[{line_q, beat_cnt}];
    end
  end

endmodule

/* icache_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~
// icache fetch controller
// lookup, line refill over the burst link, ready pulse
// ~~~~~~~~~~~~~~~~~~~~
module icache_ctrl import mem_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_en,
  input  fetch_addr_u             fetch_addr,
  output logic                    fetch_busy,
  output logic                    fetch_ready,
  output fetch_addr_u             cur_addr,
  input  logic                    tag_hit,
  output logic                    tag_set,
  output logic                    beat_we,
  output logic [BEAT_IX_BITS-1:0] beat_ix,
  output br_req_t                 br_req,
  input  br_rsp_t                 br_rsp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_REQUEST,
    S_COLLECT,
    S_READ
  } state_t;

  state_t                  state;
  fetch_addr_u             addr_q;
  logic [BEAT_IX_BITS-1:0] beat_cnt;
  logic                    last_beat;

  // every valid beat in collect goes straight into the line store
  assign beat_we   = (state == S_COLLECT) && br_rsp.rd_valid;
  assign beat_ix   = beat_cnt;
  assign last_beat = beat_we && (beat_cnt == BEAT_IX_BITS'(BEATS_PER_LINE - 1));
  // tag and valid land on the same edge as the final beat
  assign tag_set   = last_beat;

  assign fetch_busy = (state != S_IDLE);
  assign cur_addr   = addr_q;

  // line address is the word address without the word index
  assign br_req.cmd_en    = (state == S_REQUEST) && !br_rsp.busy;
  assign br_req.line_addr = addr_q.flat[FETCH_ADDR_BITS-1 -: LINE_ADDR_BITS];

  // address sampled only with an accepted strobe
  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && fetch_en) begin
      addr_q <= fetch_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      fetch_ready <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      fetch_ready <= 1'b0;
      case (state)
        // strobes outside idle are dropped
        S_IDLE: if (fetch_en) state <= S_LOOKUP;
        // tags and line store register the new address here
        S_LOOKUP: state <= S_READ;
        S_READ: begin
          if (tag_hit) begin
            fetch_ready <= 1'b1;
            state       <= S_IDLE;
          end else begin
            state <= S_REQUEST;
          end
        end
        // hold off while the burst ram finishes a previous burst
        S_REQUEST: begin
          if (!br_rsp.busy) begin
            beat_cnt <= '0;
            state    <= S_COLLECT;
          end
        end
        S_COLLECT: begin
          if (beat_we) begin
            beat_cnt <= beat_cnt + 1'b1;
            // look up again so the word comes from the new line
            if (last_beat) state <= S_LOOKUP;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* icache_lines.sv */
// ~~~~~~~~~~~~~~~~~~~~
// icache line data store
// filled one 64 bit beat at a time, read one word
// ~~~~~~~~~~~~~~~~~~~~
module icache_lines import mem_pkg::*; (
  input  logic                    clk,
  input  fetch_addr_u             addr,
  input  logic                    beat_we,
  input  logic [BEAT_IX_BITS-1:0] beat_ix,
  input  logic [BEAT_BITS-1:0]    beat_data,
  output logic [INSTR_BITS-1:0]   instr
);

  localparam int SLOT_BITS = LINE_IX_BITS + BEAT_IX_BITS;

  // entry index is {line, beat}
  logic [BEAT_BITS-1:0]  beats [2**SLOT_BITS];

  logic [SLOT_BITS-1:0]  wr_slot;
  logic [SLOT_BITS-1:0]  rd_slot;
  logic [BEAT_BITS-1:0]  rd_beat;

  assign wr_slot = {addr.f.line, beat_ix};
  // upper word index bits pick the beat
  assign rd_slot = {addr.f.line, addr.f.word[WORD_IX_BITS-1:1]};
  assign rd_beat = beats[rd_slot];

  // refill writes, one beat per valid strobe
  always_ff @(posedge clk) begin
    if (beat_we) begin
      beats[wr_slot] <= beat_data;
    end
  end

  // even words live in the low half of a beat
  always_ff @(posedge clk) begin
    if (addr.f.word[0]) begin
      instr <= rd_beat[INSTR_BITS +: INSTR_BITS];
    end else begin
      instr <= rd_beat[0 +: INSTR_BITS];
    end
  end

endmodule

/* icache_tags.sv */
// ~~~~~~~~~~~~~~~~~~~~
// icache tag store
// one tag and valid bit per line, registered hit
// ~~~~~~~~~~~~~~~~~~~~
module icache_tags import mem_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  fetch_addr_u lookup,
  input  logic        set,
  output logic        hit
);

  localparam int NUM_LINES = 2**LINE_IX_BITS;

  logic [TAG_BITS-1:0]  tag_mem [NUM_LINES];
  logic [NUM_LINES-1:0] valid;

  // per line valid bits and the registered compare
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      hit   <= 1'b0;
    end else begin
      // compare sees the tag from before a same-edge set
      hit <= valid[lookup.f.line] && (tag_mem[lookup.f.line] == lookup.f.tag);
      if (set) begin
        valid[lookup.f.line] <= 1'b1;
      end
    end
  end

  // tag written once the refill of its line is complete
  always_ff @(posedge clk) begin
    if (set) begin
      tag_mem[lookup.f.line] <= lookup.f.tag;
    end
  end

endmodule

/* data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~
// data ram, port A
// byte lane writes, registered read-first output
// ~~~~~~~~~~~~~~~~~~~~
module data_ram import mem_pkg::*; #(
  parameter int DEPTH_BITS = 10
) (
  input  logic                    clk,
  input  logic [INSTR_BITS/8-1:0] we,
  input  logic [DEPTH_BITS-1:0]   addr,
  input  logic [INSTR_BITS-1:0]   wdata,
  output logic [INSTR_BITS-1:0]   rdata
);

  localparam int NUM_LANES = INSTR_BITS / 8;

  // one word per entry, written per byte column
  logic [INSTR_BITS-1:0] mem [2**DEPTH_BITS];

  always_ff @(posedge clk) begin
    // each enabled lane updates on its own
    for (int i = 0; i < NUM_LANES; i++) begin
      if (we[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
    // nonblocking read returns the word from before this edge
    rdata <= mem[addr];
  end

endmodule

/* mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// memory subsystem shared definitions
// widths, fetch address views and the burst link bundles
// ~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

  // instruction and data word
  localparam int INSTR_BITS      = 32;
  // 8 words per line, 2 lines, 6 bit tag
  localparam int WORD_IX_BITS    = 3;
  localparam int LINE_IX_BITS    = 1;
  localparam int TAG_BITS        = 6;
  localparam int FETCH_ADDR_BITS = TAG_BITS + LINE_IX_BITS + WORD_IX_BITS;
  // burst ram addresses whole lines
  localparam int LINE_ADDR_BITS  = TAG_BITS + LINE_IX_BITS;
  // four 64 bit beats carry one 32 byte line
  localparam int BEAT_BITS       = 64;
  localparam int BEATS_PER_LINE  = 4;
  localparam int BEAT_IX_BITS    = $clog2(BEATS_PER_LINE);

  // fetch word address split into cache fields, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]     tag;
    logic [LINE_IX_BITS-1:0] line;
    logic [WORD_IX_BITS-1:0] word;
  } fetch_fields_t;

  // same 10 bits seen flat or as tag / line / word
  typedef union packed {
    logic [FETCH_ADDR_BITS-1:0] flat;
    fetch_fields_t              f;
  } fetch_addr_u;

  // controller to burst ram
  typedef struct packed {
    logic                      cmd_en;
    logic [LINE_ADDR_BITS-1:0] line_addr;
  } br_req_t;

  // burst ram back to controller
  typedef struct packed {
    logic                 busy;
    logic                 rd_valid;
    logic [BEAT_BITS-1:0] rd_data;
  } br_rsp_t;

  // preload of one beat into burst ram
  typedef struct packed {
    logic                      en;
    logic [LINE_ADDR_BITS-1:0] line_addr;
    logic [BEAT_IX_BITS-1:0]   beat;
    logic [BEAT_BITS-1:0]      data;
  } load_t;

endpackage
